// ==== source/mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

////////////////////////////////////////////////////////////
// data memory geometry
////////////////////////////////////////////////////////////

// words per byte bank, four banks make one 32-bit word
`define MEM_DEPTH 256

// word index width, taken from addr[MEM_IDX_W+1:2]
`define MEM_IDX_W 8

////////////////////////////////////////////////////////////
// memory mapped registers
////////////////////////////////////////////////////////////

// sw here sets the flag from data bit 0
`define MMIO_FLAG_ADDR 32'haaaaa004

// sw here loads the full 32-bit data register
`define MMIO_DATA_ADDR 32'haaaaa008

`endif

// ==== source/mem_pkg.sv ====
package mem_pkg;

  ////////////////////////////////////////////////////////////
  // memory opcodes
  ////////////////////////////////////////////////////////////

  // op_none covers every instruction that skips memory
  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lh   = 4'd2,
    op_lw   = 4'd3,
    op_lbu  = 4'd4,
    op_lhu  = 4'd5,
    op_sb   = 4'd6,
    op_sh   = 4'd7,
    op_sw   = 4'd8
  } mem_op_e;

  ////////////////////////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////////////////////////

  // metadata handed to the aligner at accept
  typedef struct packed {
    mem_op_e     op;
    logic [1:0]  offset;
    logic [4:0]  rd;
    logic        regwrite;
    logic [31:0] addr;
  } issue_t;

  // instruction leaving the output slot
  typedef struct packed {
    logic [4:0]  rd;
    logic        regwrite;
    logic [31:0] result;
  } retire_t;

endpackage

// ==== source/mem_lane_if.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

interface mem_lane_if;

  // write strobe for this lane
  logic                  we;
  // word index, same on all four lanes
  logic [`MEM_IDX_W-1:0] idx;
  // byte already rotated into this lane
  logic [7:0]            wdata;
  // load access, bank captures a new byte
  logic                  rd_en;
  // registered bank output
  logic [7:0]            rdata;

  ////////////////////////////////////////////////////////////
  // views
  ////////////////////////////////////////////////////////////

  // steering side
  modport req (
    output we,
    output idx,
    output wdata,
    output rd_en
  );

  // ram side
  modport bank (
    input  we,
    input  idx,
    input  wdata,
    input  rd_en,
    output rdata
  );

  // aligner only looks at read data
  modport rsp (
    input rdata
  );

endinterface

// ==== source/mem_req_steer.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_req_steer (
  input  logic             bus,
  input  logic             rst_n,
  input  logic             in_valid,
  input  mem_pkg::mem_op_e in_op,
  input  logic [31:0]      in_addr,
  input  logic [31:0]      in_wdata,
  input  logic [4:0]       in_rs2,
  input  logic [4:0]       in_rd,
  input  logic             in_regwrite,
  input  logic             slot_free,
  input  logic             retire,
  input  mem_pkg::retire_t retire_info,
  output logic             issue,
  output mem_pkg::issue_t  issue_info,
  output logic             mmio_flag,
  output logic [31:0]      mmio_data,
  mem_lane_if.req          lane [4]
);
  import mem_pkg::*;

  logic        accept;
  logic        is_load;
  logic        is_store;
  logic        mmio_flag_hit;
  logic        mmio_data_hit;
  logic        mmio_hit;
  retire_t     last_q;
  retire_t     prev;
  logic        fwd_hit;
  logic [31:0] st_data;
  logic [31:0] wdata_rot;
  logic [3:0]  byte_en;
  logic [3:0]  lane_we;
  logic        lane_rd;

  ////////////////////////////////////////////////////////////
  // accept and decode
  ////////////////////////////////////////////////////////////

  assign accept   = in_valid && slot_free;
  assign is_load  = in_op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
  assign is_store = in_op inside {op_sb, op_sh, op_sw};

  // only full word stores hit the mmio registers
  assign mmio_flag_hit = (in_op == op_sw) && (in_addr == `MMIO_FLAG_ADDR);
  assign mmio_data_hit = (in_op == op_sw) && (in_addr == `MMIO_DATA_ADDR);
  assign mmio_hit      = mmio_flag_hit || mmio_data_hit;

  assign issue      = accept;
  assign issue_info = '{op: in_op, offset: in_addr[1:0], rd: in_rd,
                        regwrite: in_regwrite, addr: in_addr};

  ////////////////////////////////////////////////////////////
  // store data forwarding
  ////////////////////////////////////////////////////////////

  // last retired instruction
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      last_q <= '0;
    end else if (retire) begin
      last_q <= retire_info;
    end
  end

  // slot retiring in the accept cycle is the previous instruction
  assign prev = retire ? retire_info : last_q;

  // x0 never forwards
  assign fwd_hit = is_store && prev.regwrite && (prev.rd != 5'd0) && (prev.rd == in_rs2);
  assign st_data = fwd_hit ? prev.result : in_wdata;

  ////////////////////////////////////////////////////////////
  // lane steering
  ////////////////////////////////////////////////////////////

  // rotate left by byte offset
  // sh at offset 3 wraps to lane 0
  always_comb begin
    case (in_addr[1:0])
      2'd0:    wdata_rot = st_data;
      2'd1:    wdata_rot = {st_data[23:0], st_data[31:24]};
      2'd2:    wdata_rot = {st_data[15:0], st_data[31:16]};
      default: wdata_rot = {st_data[7:0], st_data[31:8]};
    endcase
  end

  always_comb begin
    byte_en = 4'b0000;
    case (in_op)
      op_sb: byte_en = 4'b0001 << in_addr[1:0];
      op_sh: begin
        case (in_addr[1:0])
          2'd0:    byte_en = 4'b0011;
          2'd1:    byte_en = 4'b0110;
          2'd2:    byte_en = 4'b1100;
          default: byte_en = 4'b1001;
        endcase
      end
      // mmio words stay out of the banks
      op_sw:   byte_en = mmio_hit ? 4'b0000 : 4'b1111;
      default: byte_en = 4'b0000;
    endcase
  end

  assign lane_we = accept ? byte_en : 4'b0000;
  assign lane_rd = accept && is_load;

  for (genvar i = 0; i < 4; i++) begin : g_lane
    assign lane[i].we    = lane_we[i];
    assign lane[i].rd_en = lane_rd;
    assign lane[i].idx   = in_addr[`MEM_IDX_W+1:2];
    assign lane[i].wdata = wdata_rot[8*i +: 8];
  end

  ////////////////////////////////////////////////////////////
  // mmio registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      mmio_flag <= 1'b0;
      mmio_data <= '0;
    end else if (accept) begin
      if (mmio_flag_hit) begin
        mmio_flag <= st_data[0];
      end
      if (mmio_data_hit) begin
        mmio_data <= st_data;
      end
    end
  end

  // mmio store never leaks into a bank
  a_mmio_no_write: assert property (@(posedge bus) disable iff (!rst_n)
    (accept && (in_op == op_sw)
     && ((in_addr == `MMIO_FLAG_ADDR) || (in_addr == `MMIO_DATA_ADDR)))
    |-> !(lane[0].we || lane[1].we || lane[2].we || lane[3].we));

  // request waiting on a full slot holds still until accepted
  a_req_hold: assert property (@(posedge bus) disable iff (!rst_n)
    (in_valid && !slot_free) |=> (in_valid && $stable(in_op) && $stable(in_addr)
      && $stable(in_wdata) && $stable(in_rs2)));

endmodule

// ==== source/mem_byte_bank.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_byte_bank #(
  parameter int unsigned DEPTH = `MEM_DEPTH
) (
  input logic      bus,
  mem_lane_if.bank lane
);

  logic [7:0]            mem [DEPTH];
  logic [`MEM_IDX_W-1:0] idx;
  logic [7:0]            rdata_q;

  assign idx = lane.idx;

  ////////////////////////////////////////////////////////////
  // ram array
  ////////////////////////////////////////////////////////////

  // contents start undefined
  always_ff @(posedge bus) begin
    if (lane.we) begin
      mem[idx] <= lane.wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // read register
  ////////////////////////////////////////////////////////////

  // read-before-write, old byte on a colliding access
  // holds while idle so a stalled slot keeps its data
  always_ff @(posedge bus) begin
    if (lane.rd_en || lane.we) begin
      rdata_q <= mem[idx];
    end
  end

  assign lane.rdata = rdata_q;

endmodule

// ==== source/mem_load_align.sv ====
`timescale 1ns/1ps

module mem_load_align (
  input  logic             bus,
  input  logic             rst_n,
  input  logic             issue,
  input  mem_pkg::issue_t  issue_info,
  input  logic             out_ready,
  mem_lane_if.rsp          lane [4],
  output logic             slot_free,
  output logic             out_valid,
  output logic [4:0]       out_rd,
  output logic             out_regwrite,
  output logic [31:0]      out_result,
  output logic             retire,
  output mem_pkg::retire_t retire_info
);
  import mem_pkg::*;

  issue_t      meta_q;
  logic        valid_q;
  logic [7:0]  lane_byte [4];
  logic [31:0] word_rot;
  logic [31:0] load_val;

  ////////////////////////////////////////////////////////////
  // output slot
  ////////////////////////////////////////////////////////////

  assign slot_free = !valid_q || out_ready;
  assign retire    = valid_q && out_ready;

  // issue wins over a same-cycle retire
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (issue) begin
      valid_q <= 1'b1;
    end else if (retire) begin
      valid_q <= 1'b0;
    end
  end

  // metadata lines up with the bank read register
  always_ff @(posedge bus) begin
    if (issue) begin
      meta_q <= issue_info;
    end
  end

  ////////////////////////////////////////////////////////////
  // load alignment
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 4; i++) begin : g_lane
    assign lane_byte[i] = lane[i].rdata;
  end

  // rotate back right by the byte offset
  always_comb begin
    case (meta_q.offset)
      2'd0:    word_rot = {lane_byte[3], lane_byte[2], lane_byte[1], lane_byte[0]};
      2'd1:    word_rot = {lane_byte[0], lane_byte[3], lane_byte[2], lane_byte[1]};
      2'd2:    word_rot = {lane_byte[1], lane_byte[0], lane_byte[3], lane_byte[2]};
      default: word_rot = {lane_byte[2], lane_byte[1], lane_byte[0], lane_byte[3]};
    endcase
  end

  // sign or zero extension, non-loads pass the alu result
  always_comb begin
    case (meta_q.op)
      op_lb:   load_val = {{24{word_rot[7]}}, word_rot[7:0]};
      op_lh:   load_val = {{16{word_rot[15]}}, word_rot[15:0]};
      op_lw:   load_val = word_rot;
      op_lbu:  load_val = {24'd0, word_rot[7:0]};
      op_lhu:  load_val = {16'd0, word_rot[15:0]};
      default: load_val = meta_q.addr;
    endcase
  end

  assign out_valid    = valid_q;
  assign out_rd       = meta_q.rd;
  assign out_regwrite = meta_q.regwrite;
  assign out_result   = load_val;

  assign retire_info = '{rd: meta_q.rd, regwrite: meta_q.regwrite, result: load_val};

  // stalled result holds, banks and metadata both frozen
  a_stall_stable: assert property (@(posedge bus) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_result)));

endmodule

// ==== source/mem_stage_top.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_stage_top (
  input  logic             bus,
  input  logic             rst_n,
  // request side
  input  logic             in_valid,
  output logic             in_ready,
  input  mem_pkg::mem_op_e in_op,
  input  logic [31:0]      in_addr,
  input  logic [31:0]      in_wdata,
  input  logic [4:0]       in_rs2,
  input  logic [4:0]       in_rd,
  input  logic             in_regwrite,
  // result side
  output logic             out_valid,
  input  logic             out_ready,
  output logic [4:0]       out_rd,
  output logic             out_regwrite,
  output logic [31:0]      out_result,
  // mmio outputs
  output logic             mmio_flag,
  output logic [31:0]      mmio_data
);
  import mem_pkg::*;

  logic    slot_free;
  logic    issue;
  issue_t  issue_info;
  logic    retire;
  retire_t retire_info;

  // one lane per byte of the word
  mem_lane_if lane [4] ();

  assign in_ready = slot_free;

  ////////////////////////////////////////////////////////////
  // request steering and mmio
  ////////////////////////////////////////////////////////////

  mem_req_steer u_steer (
    .bus         (bus),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_op       (in_op),
    .in_addr     (in_addr),
    .in_wdata    (in_wdata),
    .in_rs2      (in_rs2),
    .in_rd       (in_rd),
    .in_regwrite (in_regwrite),
    .slot_free   (slot_free),
    .retire      (retire),
    .retire_info (retire_info),
    .issue       (issue),
    .issue_info  (issue_info),
    .mmio_flag   (mmio_flag),
    .mmio_data   (mmio_data),
    .lane        (lane)
  );

  ////////////////////////////////////////////////////////////
  // byte banks
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 4; i++) begin : g_bank
    mem_byte_bank #(
      .DEPTH (`MEM_DEPTH)
    ) u_bank (
      .bus  (bus),
      .lane (lane[i])
    );
  end

  // output slot and load alignment
  mem_load_align u_align (
    .bus          (bus),
    .rst_n        (rst_n),
    .issue        (issue),
    .issue_info   (issue_info),
    .out_ready    (out_ready),
    .lane         (lane),
    .slot_free    (slot_free),
    .out_valid    (out_valid),
    .out_rd       (out_rd),
    .out_regwrite (out_regwrite),
    .out_result   (out_result),
    .retire       (retire),
    .retire_info  (retire_info)
  );

endmodule

// ==== testbench/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage;
  import mem_pkg::*;

  // ten hex words per request record
  localparam int NUM_PAT     = 29;
  localparam int REC_W       = 10;
  localparam int CYCLE_LIMIT = NUM_PAT * 8 + 50;

  logic        bus = 1'b0;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  mem_op_e     in_op;
  logic [31:0] in_addr;
  logic [31:0] in_wdata;
  logic [4:0]  in_rs2;
  logic [4:0]  in_rd;
  logic        in_regwrite;
  logic        out_valid;
  logic        out_ready;
  logic [4:0]  out_rd;
  logic        out_regwrite;
  logic [31:0] out_result;
  logic        mmio_flag;
  logic [31:0] mmio_data;

  // id op addr wdata rs2 rd regwrite result flag data
  logic [31:0] pat [0:NUM_PAT*REC_W-1];
  integer      seed = 18644;
  int          res_idx = 0;
  int          cycle_cnt = 0;
  logic        stall_seen = 1'b0;
  logic [31:0] held_result;
  logic [4:0]  held_rd;
  logic        held_regwrite;

  always #10 bus = ~bus;

  mem_stage_top uut (
    .bus          (bus),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_op        (in_op),
    .in_addr      (in_addr),
    .in_wdata     (in_wdata),
    .in_rs2       (in_rs2),
    .in_rd        (in_rd),
    .in_regwrite  (in_regwrite),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_rd       (out_rd),
    .out_regwrite (out_regwrite),
    .out_result   (out_result),
    .mmio_flag    (mmio_flag),
    .mmio_data    (mmio_data)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_field(input string name, input logic [31:0] id,
                               input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("mismatch test %0h %s: expected %h actual %h", id, name, expected, actual);
      abort_run();
    end
  endtask

  // one retired result against the next record in order
  task automatic check_output();
    int base;
    base = res_idx * REC_W;
    assert (res_idx < NUM_PAT) else begin
      $display("extra result %h showed up after the last request", out_result);
      abort_run();
    end
    compare_field("out_result", pat[base], pat[base+7], out_result);
    compare_field("out_rd", pat[base], pat[base+5], {27'd0, out_rd});
    compare_field("out_regwrite", pat[base], pat[base+6], {31'd0, out_regwrite});
    // mmio already holds this request
    // the next accept lands on the same edge as this retire
    compare_field("mmio_flag", pat[base], pat[base+8], {31'd0, mmio_flag});
    compare_field("mmio_data", pat[base], pat[base+9], mmio_data);
    res_idx++;
  endtask

  // drive on the rising edge
  // hold until in_ready seen
  task automatic send_request(input int k);
    int base;
    base = k * REC_W;
    @(posedge bus);
    in_valid    <= 1'b1;
    in_op       <= mem_op_e'(pat[base+1][3:0]);
    in_addr     <= pat[base+2];
    in_wdata    <= pat[base+3];
    in_rs2      <= pat[base+4][4:0];
    in_rd       <= pat[base+5][4:0];
    in_regwrite <= pat[base+6][0];
    @(negedge bus);
    while (!in_ready) begin
      @(negedge bus);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // back-pressure, monitor, timeout
  ////////////////////////////////////////////////////////////

  // ready about three cycles in four
  always @(posedge bus) begin
    out_ready <= (($random(seed) & 3) != 0);
  end

  // negedge view equals the values the next rising edge uses
  always @(negedge bus) begin
    if (rst_n) begin
      if (stall_seen) begin
        assert (out_valid && out_result === held_result && out_rd === held_rd
                && out_regwrite === held_regwrite) else begin
          $display("stalled output for request %0d changed before out_ready", res_idx);
          abort_run();
        end
      end
      stall_seen    = out_valid && !out_ready;
      held_result   = out_result;
      held_rd       = out_rd;
      held_regwrite = out_regwrite;
      if (out_valid && out_ready) begin
        check_output();
      end
    end
  end

  always @(posedge bus) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: %0d of %0d results after %0d cycles", res_idx, NUM_PAT, cycle_cnt);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    $readmemh("testbench/mem_patterns.txt", pat);
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_op       = op_none;
    in_addr     = '0;
    in_wdata    = '0;
    in_rs2      = '0;
    in_rd       = '0;
    in_regwrite = 1'b0;
    out_ready   = 1'b0;
    repeat (2) @(posedge bus);
    rst_n <= 1'b1;
    for (int k = 0; k < NUM_PAT; k++) begin
      send_request(k);
    end
    @(posedge bus);
    in_valid <= 1'b0;
    wait (res_idx == NUM_PAT);
    // a few idle cycles to catch a duplicate result
    repeat (4) @(posedge bus);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== testbench/mem_patterns.txt ====
// id op addr wdata rs2 rd regwrite result mmio_flag mmio_data, all hex
// op 0 none 1 lb 2 lh 3 lw 4 lbu 5 lhu 6 sb 7 sh 8 sw, mmio columns after the request
01 8 00000100 12345678 00 00 0 00000100 0 00000000
02 3 00000100 00000000 00 01 1 12345678 0 00000000
03 0 deadbeef 00000000 00 02 1 deadbeef 0 00000000
04 6 00000104 000000a1 00 00 0 00000104 0 00000000
05 6 00000105 000000b2 00 00 0 00000105 0 00000000
06 6 00000106 ffffffc3 00 00 0 00000106 0 00000000
07 6 00000107 000000d4 00 00 0 00000107 0 00000000
08 3 00000104 00000000 00 03 1 d4c3b2a1 0 00000000
09 8 00000108 11223344 00 00 0 00000108 0 00000000
0a 7 0000010b 0000beef 00 00 0 0000010b 0 00000000
0b 3 00000108 00000000 00 04 1 ef2233be 0 00000000
0c 2 0000010b 00000000 00 04 1 ffffbeef 0 00000000
0d 1 00000105 00000000 00 06 1 ffffffb2 0 00000000
0e 4 00000106 00000000 00 06 1 000000c3 0 00000000
0f 2 00000106 00000000 00 06 1 ffffd4c3 0 00000000
10 5 00000104 00000000 00 06 1 0000b2a1 0 00000000
11 3 00000100 00000000 00 05 1 12345678 0 00000000
12 8 0000010c cafef00d 05 00 0 0000010c 0 00000000
13 3 0000010c 00000000 00 07 1 12345678 0 00000000
14 3 00000104 00000000 00 00 1 d4c3b2a1 0 00000000
15 8 00000110 0badcafe 00 00 0 00000110 0 00000000
16 3 00000110 00000000 00 08 1 0badcafe 0 00000000
17 8 00000004 55aa55aa 00 00 0 00000004 0 00000000
18 8 aaaaa004 00000001 00 00 0 aaaaa004 1 00000000
19 8 aaaaa008 feedface 00 00 0 aaaaa008 1 feedface
1a 3 00000004 00000000 00 09 1 55aa55aa 1 feedface
1b 3 aaaaa004 00000000 00 09 1 55aa55aa 1 feedface
1c 8 aaaaa004 00000002 00 00 0 aaaaa004 0 feedface
1d 0 00000040 00000000 00 0a 1 00000040 0 feedface

// ==== flist.f ====
+incdir+source
source/mem_pkg.sv
source/mem_lane_if.sv
source/mem_req_steer.sv
source/mem_byte_bank.sv
source/mem_load_align.sv
source/mem_stage_top.sv
testbench/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - include_dirs:
      - source
    files:
      - source/mem_pkg.sv
      - source/mem_lane_if.sv
      - source/mem_req_steer.sv
      - source/mem_byte_bank.sv
      - source/mem_load_align.sv
      - source/mem_stage_top.sv

  - target: test
    files:
      - testbench/tb_mem_stage.sv
